//--- sigGenTop.f
src/sigGenPkg.sv
src/startCatch.sv
src/creditGate.sv
src/burstSequencer.sv
src/pulseShaper.sv
src/lfsrSource.sv
src/sigGenTop.sv
dv/sigGenTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
# the log decides pass or fail

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -sv --assert \
  -f sigGenTop.f \
  --top-module sigGenTb \
  -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { echo "build or simulation aborted"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Everything OK" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

//--- dv/sigGenTb.sv
`timescale 1ns/1ps

// testbench for the test-signal source
// table rows start bursts, a credit consumer drains them
module sigGenTb;

  localparam int seqLen     = 20;
  localparam int maxCredits = 4;
  localparam int w          = sigGenPkg::sampleWidth;
  localparam int leadIn     = sigGenPkg::leadIn;
  // longest burst is the dirac one
  localparam int maxBeats   = leadIn + 2 * seqLen + 1;
  localparam int numRows    = 10;
  localparam int stallCycles    = maxCredits + 8;
  localparam int resumeProb     = 9;
  localparam int watchdogCycles = numRows * maxBeats * 20 + 200;

  // cfg, return chance out of 16, restart flag, cfg for the restart
  typedef struct packed {
    sigGenPkg::waveCfg_t cfg;
    logic [4:0]          prob;
    logic                doRestart;
    sigGenPkg::waveCfg_t restartCfg;
  } row_t;

  logic                   clk;
  logic                   nGrst;
  logic                   start;
  logic                   creditReturn;
  sigGenPkg::waveCfg_t    cfg;
  logic                   beatValid;
  logic                   busy;
  sigGenPkg::sampleBeat_t beat;

  row_t                rowTable [numRows];
  logic signed [w-1:0] expData  [maxBeats];
  logic signed [w-1:0] rxData   [maxBeats];
  logic signed [w-1:0] prevRand [maxBeats];
  int                  expLen;
  int                  rxCount;
  int                  prevRandLen;
  bit                  prevRandValid;
  bit                  burstDone;
  // beats received and not yet handed back as credits
  int                  owed;
  int                  curProb;
  int                  checkErrors;
  int                  otherErrors;
  int                  beatsSeen;
  logic [31:0]         rngState;

  sigGenTop #(
    .seqLen     (seqLen),
    .maxCredits (maxCredits)
  ) u_dut (
    .clk          (clk),
    .nGrst        (nGrst),
    .start        (start),
    .creditReturn (creditReturn),
    .cfg          (cfg),
    .beatValid    (beatValid),
    .busy         (busy),
    .beat         (beat)
  );

  always #50 clk = ~clk;

  // right-shift galois step with taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // four fresh bits with one step per bit
  task automatic randomNibble(output logic [3:0] nib);
    nib = 4'd0;
    for (int i = 0; i < 4; i++) begin
      nib = {nib[2:0], rngState[0]};
      rngState = galoisStep(rngState);
    end
  endtask

  // reference lfsr step
  // top bit xor (low bits all zero) feeds bit 0 and the tapped bits
  function automatic logic [w-1:0] lfsrNext(input logic [w-1:0] s);
    logic         fb;
    logic [w-1:0] n;
    fb   = s[w-1] ^ (s[w-2:0] == '0);
    n[0] = fb;
    for (int b = 1; b < w; b++) begin
      n[b] = sigGenPkg::lfsrTaps[b-1] ? (s[b-1] ^ fb) : s[b-1];
    end
    return n;
  endfunction

  function automatic sigGenPkg::waveCfg_t shapeCfg(input sigGenPkg::waveMode_t mode,
                                                    input logic full, input logic neg);
    sigGenPkg::waveCfg_t c;
    c.mode     = mode;
    c.amplFull = full;
    c.negAmpl  = neg;
    return c;
  endfunction

  function automatic row_t tableRow(input sigGenPkg::waveCfg_t c, input logic [4:0] prob,
                                    input logic rst, input sigGenPkg::waveCfg_t rc);
    row_t r;
    r.cfg        = c;
    r.prob       = prob;
    r.doRestart  = rst;
    r.restartCfg = rc;
    return r;
  endfunction

  // expected beats of one burst
  task automatic buildExpected(input sigGenPkg::waveCfg_t c);
    logic signed [w-1:0] ampl;
    logic [w-1:0]        st;
    ampl = c.amplFull ? w'((1 << (w - 1)) - 1) : w'(1);
    st   = '0;
    case (c.mode)
      sigGenPkg::waveDirac: begin
        expLen = leadIn + 2 * seqLen + 1;
        for (int k = 0; k < expLen; k++) begin
          expData[k] = (k == leadIn) ? ampl : (k == leadIn + seqLen) ? -ampl : '0;
        end
      end
      sigGenPkg::waveStep: begin
        expLen = leadIn + seqLen + 1;
        for (int k = 0; k < expLen; k++) begin
          expData[k] = c.negAmpl ? -ampl : ampl;
        end
      end
      sigGenPkg::waveRandom: begin
        expLen     = leadIn + seqLen + 1;
        expData[0] = '0;
        for (int k = 1; k < expLen; k++) begin
          st         = lfsrNext(st);
          expData[k] = $signed(st);
        end
      end
      default: begin
        expLen = 0;
        otherErrors++;
        $display("table row holds an unknown wave mode");
      end
    endcase
  endtask

  // consumer handing credits back at the row's rate
  initial begin
    logic [3:0] nib;
    creditReturn = 1'b0;
    forever begin
      @(posedge clk);
      #5;
      creditReturn = 1'b0;
      if (nGrst && owed > 0) begin
        randomNibble(nib);
        if (int'(nib) < curProb) begin
          creditReturn = 1'b1;
          owed--;
        end
      end
    end
  end

  // beat monitor samples mid-cycle where everything has settled
  always @(negedge clk) begin
    if (nGrst && beatValid) begin
      beatsSeen++;
      if (!busy) begin
        otherErrors++;
        $display("beat sent while busy was low");
      end
      if (rxCount >= expLen) begin
        otherErrors++;
        $display("beat received after the end of the burst");
      end else begin
        if (beat.data !== expData[rxCount]) begin
          checkErrors++;
          $display("CHECK FAILED beat.data k=%0d expected %h actual %h",
                   rxCount, expData[rxCount], beat.data);
        end
        if (beat.last !== (rxCount == expLen - 1)) begin
          checkErrors++;
          $display("CHECK FAILED beat.last k=%0d expected %h actual %h",
                   rxCount, (rxCount == expLen - 1), beat.last);
        end
        rxData[rxCount] = beat.data;
      end
      rxCount++;
      owed++;
      if (owed > maxCredits) begin
        otherErrors++;
        $display("%0d beats in flight, buffer holds only %0d", owed, maxCredits);
      end
      if (rxCount == expLen) begin
        burstDone = 1'b1;
      end
    end
  end

  // one table row with optional stall and restart
  task automatic runRow(input int r);
    row_t                row;
    sigGenPkg::waveCfg_t finalCfg;
    row      = rowTable[r];
    finalCfg = row.cfg;
    buildExpected(row.cfg);
    rxCount   = 0;
    burstDone = 1'b0;
    curProb   = int'(row.prob);
    @(posedge clk);
    #5;
    cfg   = row.cfg;
    start = 1'b1;
    @(posedge clk);
    #5;
    start = 1'b0;
    if (row.prob == 5'd0) begin
      // no returns, so only the buffer depth gets through
      repeat (stallCycles) @(posedge clk);
      if (rxCount != maxCredits) begin
        otherErrors++;
        $display("row %0d: %0d beats with no credits returned, expected %0d",
                 r, rxCount, maxCredits);
      end
      if (row.doRestart) begin
        #5;
        finalCfg = row.restartCfg;
        cfg      = row.restartCfg;
        start    = 1'b1;
        buildExpected(row.restartCfg);
        rxCount = 0;
        @(posedge clk);
        #5;
        start = 1'b0;
        repeat (3) @(posedge clk);
        if (rxCount != 0) begin
          otherErrors++;
          $display("row %0d: beat sent after restart with no credit", r);
        end
      end
      curProb = resumeProb;
    end
    while (!burstDone) @(posedge clk);
    // cycle after the last beat
    @(negedge clk);
    if (busy !== 1'b0) begin
      checkErrors++;
      $display("CHECK FAILED busy expected %h actual %h", 1'b0, busy);
    end
    if (beatValid !== 1'b0) begin
      checkErrors++;
      $display("CHECK FAILED beatValid expected %h actual %h", 1'b0, beatValid);
    end
    // drain every credit before the next row
    curProb = 16;
    while (owed != 0) @(posedge clk);
    if (rxCount != expLen) begin
      otherErrors++;
      $display("row %0d: %0d beats received, expected %0d", r, rxCount, expLen);
    end
    // back to back random bursts repeat exactly
    if (finalCfg.mode == sigGenPkg::waveRandom) begin
      if (prevRandValid && prevRandLen == expLen) begin
        for (int k = 0; k < expLen; k++) begin
          if (rxData[k] !== prevRand[k]) begin
            checkErrors++;
            $display("CHECK FAILED beat.data repeat k=%0d expected %h actual %h",
                     k, prevRand[k], rxData[k]);
          end
        end
      end
      for (int k = 0; k < expLen; k++) begin
        prevRand[k] = rxData[k];
      end
      prevRandLen   = expLen;
      prevRandValid = 1'b1;
    end else begin
      prevRandValid = 1'b0;
    end
  endtask

  // watchdog
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdogCycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    clk           = 1'b0;
    nGrst         = 1'b0;
    start         = 1'b0;
    cfg           = shapeCfg(sigGenPkg::waveDirac, 1'b0, 1'b0);
    rngState      = 32'h31a2_be96;
    expLen        = 0;
    rxCount       = 0;
    owed          = 0;
    curProb       = 16;
    burstDone     = 1'b0;
    prevRandValid = 1'b0;
    prevRandLen   = 0;
    checkErrors   = 0;
    otherErrors   = 0;
    beatsSeen     = 0;

    // dirac both amplitudes, all step corners, two randoms in a row
    rowTable[0] = tableRow(shapeCfg(sigGenPkg::waveDirac, 1'b0, 1'b0), 5'd16, 1'b0, '0);
    rowTable[1] = tableRow(shapeCfg(sigGenPkg::waveDirac, 1'b1, 1'b0), 5'd10, 1'b0, '0);
    rowTable[2] = tableRow(shapeCfg(sigGenPkg::waveStep, 1'b0, 1'b0), 5'd16, 1'b0, '0);
    rowTable[3] = tableRow(shapeCfg(sigGenPkg::waveStep, 1'b0, 1'b1), 5'd12, 1'b0, '0);
    rowTable[4] = tableRow(shapeCfg(sigGenPkg::waveStep, 1'b1, 1'b0), 5'd8, 1'b0, '0);
    rowTable[5] = tableRow(shapeCfg(sigGenPkg::waveStep, 1'b1, 1'b1), 5'd16, 1'b0, '0);
    rowTable[6] = tableRow(shapeCfg(sigGenPkg::waveRandom, 1'b0, 1'b0), 5'd16, 1'b0, '0);
    rowTable[7] = tableRow(shapeCfg(sigGenPkg::waveRandom, 1'b0, 1'b0), 5'd6, 1'b0, '0);
    // stall, then resume
    rowTable[8] = tableRow(shapeCfg(sigGenPkg::waveDirac, 1'b1, 1'b0), 5'd0, 1'b0, '0);
    // stall, restart into random, then resume
    rowTable[9] = tableRow(shapeCfg(sigGenPkg::waveStep, 1'b1, 1'b0), 5'd0, 1'b1,
                           shapeCfg(sigGenPkg::waveRandom, 1'b0, 1'b0));

    repeat (8) @(posedge clk);
    #5;
    nGrst = 1'b1;

    // idle after reset
    repeat (6) begin
      @(negedge clk);
      if (beatValid !== 1'b0) begin
        checkErrors++;
        $display("CHECK FAILED beatValid expected %h actual %h", 1'b0, beatValid);
      end
      if (busy !== 1'b0) begin
        checkErrors++;
        $display("CHECK FAILED busy expected %h actual %h", 1'b0, busy);
      end
    end

    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end

    repeat (4) @(posedge clk);
    $display("summary: %0d beats, %0d value errors, %0d other errors",
             beatsSeen, checkErrors, otherErrors);
    if (checkErrors == 0 && otherErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- src/sigGenTop.sv
`timescale 1ns/1ps

// test-signal source top level
// start pulse -> one burst of samples under credit flow control
module sigGenTop #(
  parameter int seqLen     = 20,
  parameter int maxCredits = 4
) (
  input  logic                   clk,
  input  logic                   nGrst,
  input  logic                   start,
  input  logic                   creditReturn,
  input  sigGenPkg::waveCfg_t    cfg,
  output logic                   beatValid,
  output logic                   busy,
  output sigGenPkg::sampleBeat_t beat
);

  logic                                     startPending;
  logic                                     startTaken;
  logic                                     canSend;
  logic                                     restart;
  logic                                     last;
  sigGenPkg::waveCfg_t                      activeCfg;
  logic        [sigGenPkg::indexWidth-1:0]  index;
  logic signed [sigGenPkg::sampleWidth-1:0] shapeData;
  logic signed [sigGenPkg::sampleWidth-1:0] lfsrData;

  startCatch u_startCatch (
    .clk          (clk),
    .nGrst        (nGrst),
    .start        (start),
    .startTaken   (startTaken),
    .startPending (startPending)
  );

  // every sent beat spends a credit
  creditGate #(.maxCredits(maxCredits)) u_creditGate (
    .clk          (clk),
    .nGrst        (nGrst),
    .spend        (beatValid),
    .creditReturn (creditReturn),
    .canSend      (canSend)
  );

  burstSequencer #(.seqLen(seqLen)) u_burstSequencer (
    .clk          (clk),
    .nGrst        (nGrst),
    .canSend      (canSend),
    .startPending (startPending),
    .cfgIn        (cfg),
    .startTaken   (startTaken),
    .beatValid    (beatValid),
    .busy         (busy),
    .restart      (restart),
    .last         (last),
    .cfg          (activeCfg),
    .index        (index)
  );

  pulseShaper #(.seqLen(seqLen)) u_pulseShaper (
    .cfg   (activeCfg),
    .index (index),
    .data  (shapeData)
  );

  // lfsr steps on each sent beat
  lfsrSource u_lfsrSource (
    .clk     (clk),
    .nGrst   (nGrst),
    .advance (beatValid),
    .restart (restart),
    .data    (lfsrData)
  );

  // sample source follows the burst's own mode
  assign beat.data = (activeCfg.mode == sigGenPkg::waveRandom) ? lfsrData : shapeData;
  assign beat.last = last;

endmodule

//--- src/lfsrSource.sv
`timescale 1ns/1ps

// pseudo-random samples with one new state per sent beat
// zero-inserting feedback keeps all-zero inside the cycle
module lfsrSource (
  input  logic                                     clk,
  input  logic                                     nGrst,
  input  logic                                     advance,
  input  logic                                     restart,
  output logic signed [sigGenPkg::sampleWidth-1:0] data
);

  localparam int w = sigGenPkg::sampleWidth;

  logic [w-1:0] state;
  logic [w-1:0] stateNext;
  logic         allZeros;
  logic         feedback;

  always_comb begin
    // extra 1 slips in when the low bits are all zero
    allZeros = ~|state[w-2:0];
    feedback = state[w-1] ^ allZeros;
    stateNext[0] = feedback;
    for (int n = w - 1; n >= 1; n--) begin
      if (sigGenPkg::lfsrTaps[n-1]) begin
        stateNext[n] = state[n-1] ^ feedback;
      end else begin
        stateNext[n] = state[n-1];
      end
    end
  end

  always_ff @(posedge clk or negedge nGrst) begin
    if (!nGrst) begin
      state <= '0;
    end else if (advance && restart) begin
      // burst opens from the zero state
      state <= '0;
    end else if (advance) begin
      state <= stateNext;
    end
  end

  // k=0 is zero and every later beat shows the state it steps into
  assign data = restart ? '0 : $signed(stateNext);

endmodule

//--- src/pulseShaper.sv
`timescale 1ns/1ps

// dirac and step sample values, purely combinational
module pulseShaper #(
  parameter int seqLen = 20
) (
  input  sigGenPkg::waveCfg_t                      cfg,
  input  logic        [sigGenPkg::indexWidth-1:0]  index,
  output logic signed [sigGenPkg::sampleWidth-1:0] data
);

  localparam int w = sigGenPkg::sampleWidth;

  // dirac pulse positions
  localparam logic [sigGenPkg::indexWidth-1:0] posIdx =
    sigGenPkg::indexWidth'(sigGenPkg::leadIn);
  localparam logic [sigGenPkg::indexWidth-1:0] negIdx =
    sigGenPkg::indexWidth'(sigGenPkg::leadIn + seqLen);

  logic signed [w-1:0] ampl;
  logic signed [w-1:0] stepLevel;

  // 0111..1 for full scale, else 000..1
  assign ampl = cfg.amplFull ? {1'b0, {(w-1){1'b1}}} : w'(1);

  // sign option is for the step only
  assign stepLevel = cfg.negAmpl ? -ampl : ampl;

  always_comb begin
    data = '0;
    case (cfg.mode)
      sigGenPkg::waveDirac: begin
        // positive pulse after lead-in, negative one a shape later
        if (index == posIdx) begin
          data = ampl;
        end else if (index == negIdx) begin
          data = -ampl;
        end
      end
      sigGenPkg::waveStep: begin
        // constant level through the burst
        data = stepLevel;
      end
      default: begin
        // random samples come from the lfsr
        data = '0;
      end
    endcase
  end

endmodule

//--- src/burstSequencer.sv
`timescale 1ns/1ps

// burst owner that takes starts, counts beats and flags the last one
module burstSequencer #(
  parameter int seqLen = 20
) (
  input  logic                               clk,
  input  logic                               nGrst,
  input  logic                               canSend,
  input  logic                               startPending,
  input  sigGenPkg::waveCfg_t                cfgIn,
  output logic                               startTaken,
  output logic                               beatValid,
  output logic                               busy,
  output logic                               restart,
  output logic                               last,
  output sigGenPkg::waveCfg_t                cfg,
  output logic [sigGenPkg::indexWidth-1:0]   index
);

  logic                              busyReg;
  logic [sigGenPkg::indexWidth-1:0]  idxReg;
  logic [sigGenPkg::indexWidth-1:0]  finalIdx;
  sigGenPkg::waveCfg_t               cfgReg;

  // offer a beat when credits allow and there is work
  assign beatValid  = canSend && (busyReg || startPending);
  // pending start turns the offered beat into k=0
  assign restart    = startPending;
  assign startTaken = beatValid && startPending;

  // settings and index seen by the shapers this cycle
  assign cfg   = startPending ? cfgIn : cfgReg;
  assign index = startPending ? '0 : idxReg;

  // dirac runs two shape lengths and the others one
  always_comb begin
    if (cfg.mode == sigGenPkg::waveDirac) begin
      finalIdx = sigGenPkg::indexWidth'(sigGenPkg::leadIn + 2 * seqLen);
    end else begin
      finalIdx = sigGenPkg::indexWidth'(sigGenPkg::leadIn + seqLen);
    end
  end

  assign last = beatValid && (index == finalIdx);
  // high already on the beat that opens the burst
  assign busy = busyReg || startTaken;

  always_ff @(posedge clk or negedge nGrst) begin
    if (!nGrst) begin
      busyReg <= 1'b0;
      idxReg  <= '0;
    end else if (startTaken) begin
      // k=0 goes out now and k=1 is next
      busyReg <= 1'b1;
      idxReg  <= sigGenPkg::indexWidth'(1);
    end else if (last) begin
      busyReg <= 1'b0;
      idxReg  <= '0;
    end else if (beatValid) begin
      idxReg  <= idxReg + 1'b1;
    end
  end

  // settings only change when a start is taken
  always_ff @(posedge clk) begin
    if (startTaken) begin
      cfgReg <= cfgIn;
    end
  end

  // index never runs past the final beat of the running burst
  assert property (@(posedge clk) disable iff (!nGrst)
    busyReg && !startPending |-> idxReg <= finalIdx)
    else $error("burst index past the final beat");

endmodule

//--- src/creditGate.sv
`timescale 1ns/1ps

// credit counter for the consumer buffer
// one credit spent per sent beat, one returned per pulse
module creditGate #(
  parameter int maxCredits = 4
) (
  input  logic clk,
  input  logic nGrst,
  input  logic spend,
  input  logic creditReturn,
  output logic canSend
);

  localparam int cntWidth = $clog2(maxCredits + 1);

  logic [cntWidth-1:0] credits;
  logic [cntWidth-1:0] creditsNext;

  // spend and return together leave the count alone
  always_comb begin
    creditsNext = credits;
    case ({spend, creditReturn})
      2'b10:   creditsNext = credits - 1'b1;
      2'b01:   creditsNext = credits + 1'b1;
      default: creditsNext = credits;
    endcase
  end

  always_ff @(posedge clk or negedge nGrst) begin
    if (!nGrst) begin
      // consumer buffer starts empty
      credits <= cntWidth'(maxCredits);
    end else begin
      credits <= creditsNext;
    end
  end

  // a beat may go while any credit is left
  assign canSend = (credits != '0);

  // sequencer must respect the gate
  assert property (@(posedge clk) disable iff (!nGrst)
    spend |-> credits != '0)
    else $error("beat sent without a credit");

  // consumer must not hand back more than it received
  assert property (@(posedge clk) disable iff (!nGrst)
    credits <= cntWidth'(maxCredits))
    else $error("credit count above buffer depth");

endmodule

//--- src/startCatch.sv
`timescale 1ns/1ps

// sticky start request
// held until the sequencer uses it on a sent beat
module startCatch (
  input  logic clk,
  input  logic nGrst,
  input  logic start,
  input  logic startTaken,
  output logic startPending
);

  always_ff @(posedge clk or negedge nGrst) begin
    if (!nGrst) begin
      startPending <= 1'b0;
    end else if (start) begin
      // a fresh start wins over a take in the same cycle
      startPending <= 1'b1;
    end else if (startTaken) begin
      startPending <= 1'b0;
    end
  end

endmodule

//--- src/sigGenPkg.sv
// shared types and constants for the test-signal source
package sigGenPkg;

  // sample word width
  localparam int sampleWidth = 12;

  // burst index width, one bit wider than a sample
  // so that any shape length up to a sample range fits
  localparam int indexWidth = sampleWidth + 1;

  // idle zero beats ahead of the shape
  localparam int leadIn = 4;

  // feedback taps for the 12-bit register
  // bit n-1 set means bit n takes the xor with feedback
  localparam logic [sampleWidth-1:0] lfsrTaps = 12'b1000_0010_1001;

  // burst shape, picked per start
  typedef enum logic [1:0] {
    waveDirac  = 2'd0,
    waveStep   = 2'd1,
    waveRandom = 2'd2
  } waveMode_t;

  // run-time shape settings, 4 bits in total
  typedef struct packed {
    waveMode_t mode;
    // 0 -> amplitude 1, 1 -> largest positive sample
    logic      amplFull;
    // step only, flips the level sign
    logic      negAmpl;
  } waveCfg_t;

  // one beat toward the consumer
  typedef struct packed {
    logic signed [sampleWidth-1:0] data;
    // marks the final sample of a burst
    logic                          last;
  } sampleBeat_t;

endpackage
